// File: hdl/mask_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mask unit package
// Slice geometry, credit depths, operation codes
// and the shared vector types of the mask unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mask_pkg;

  // Vector geometry
  localparam int unsigned SliceW   = 16;
  localparam int unsigned NrSlices = 8;
  localparam int unsigned VlenBits = SliceW * NrSlices;

  // Flow control
  localparam int unsigned InDepth    = 2;
  localparam int unsigned OutCredits = 2;

  typedef logic [SliceW-1:0]                  slice_t;
  typedef logic [2:0]                         op_t;
  // Holds 0 to VlenBits inclusive
  typedef logic [$clog2(VlenBits+1)-1:0]      cnt_t;
  typedef logic [$clog2(NrSlices)-1:0]        slice_idx_t;
  typedef logic [1:0]                         credit_t;

  // Mask instructions
  localparam op_t OP_VCPOP  = 3'd0;
  localparam op_t OP_VFIRST = 3'd1;
  localparam op_t OP_VMSBF  = 3'd2;
  localparam op_t OP_VMSIF  = 3'd3;
  localparam op_t OP_VMSOF  = 3'd4;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH
  } seq_state_e;

endpackage

`default_nettype wire

// File: hdl/mask_in_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mask unit input buffer
// Two-entry FIFO for operand and mask slices that
// hands one credit back to the source per pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mask_in_fifo (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             push_i,
  input  wire mask_pkg::slice_t slice_i,
  input  wire mask_pkg::slice_t mask_i,
  input  wire logic             pop_i,
  output mask_pkg::slice_t      head_slice_o,
  output mask_pkg::slice_t      head_mask_o,
  output logic                  empty_o,
  output logic                  credit_o
);

  localparam int unsigned PtrW = $clog2(mask_pkg::InDepth);

  mask_pkg::slice_t mem_slice [mask_pkg::InDepth];
  mask_pkg::slice_t mem_mask  [mask_pkg::InDepth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]   fill_q;
  logic            credit_q;

  // Storage, written only by the source side
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_slice[wr_ptr_q] <= slice_i;
      mem_mask[wr_ptr_q]  <= mask_i;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
      fill_q   <= fill_q + (PtrW+1)'(push_i) - (PtrW+1)'(pop_i);
      // One freed entry gives one credit back
      credit_q <= pop_i;
    end
  end

  assign head_slice_o = mem_slice[rd_ptr_q];
  assign head_mask_o  = mem_mask[rd_ptr_q];
  assign empty_o      = (fill_q == '0);
  assign credit_o     = credit_q;

endmodule

`default_nettype wire

// File: hdl/mask_seq_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mask unit sequencer
// Latches the instruction, pops eight slices under
// output credit control and flags completion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mask_seq_ctrl (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          start_i,
  input  wire mask_pkg::op_t op_i,
  input  wire logic          vm_i,
  input  wire logic          fifo_empty_i,
  input  wire logic          out_credit_i,
  output logic               pop_o,
  output mask_pkg::op_t      op_o,
  output logic               vm_o,
  output logic               clr_o,
  output logic               count_en_o,
  output logic               sf_en_o,
  output logic               busy_o,
  output logic               done_o
);

  mask_pkg::seq_state_e state_q, state_d;
  mask_pkg::op_t        op_q;
  logic                 vm_q;
  mask_pkg::slice_idx_t idx_q;
  mask_pkg::credit_t    credit_q;

  logic start_ok;
  logic is_cnt, is_sf;
  logic last_pop;

  assign start_ok = start_i && (state_q == mask_pkg::IDLE);

  assign is_cnt = (op_q == mask_pkg::OP_VCPOP) || (op_q == mask_pkg::OP_VFIRST);
  assign is_sf  = (op_q == mask_pkg::OP_VMSBF) || (op_q == mask_pkg::OP_VMSIF) ||
                  (op_q == mask_pkg::OP_VMSOF);

  // Set-first slices need a free output slot, counts never wait
  assign pop_o = (state_q == mask_pkg::RUN) && !fifo_empty_i &&
                 (!is_sf || (credit_q != '0));

  assign last_pop = pop_o && (idx_q == mask_pkg::slice_idx_t'(mask_pkg::NrSlices - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      mask_pkg::IDLE:   if (start_ok) state_d = mask_pkg::RUN;
      mask_pkg::RUN:    if (last_pop) state_d = mask_pkg::FINISH;
      mask_pkg::FINISH: state_d = mask_pkg::IDLE;
      default:          state_d = mask_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= mask_pkg::IDLE;
      op_q     <= mask_pkg::OP_VCPOP;
      vm_q     <= 1'b0;
      idx_q    <= '0;
      credit_q <= mask_pkg::credit_t'(mask_pkg::OutCredits);
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        op_q  <= op_i;
        vm_q  <= vm_i;
        idx_q <= '0;
      end else if (pop_o) begin
        // Wraps back to zero after the last slice
        idx_q <= idx_q + 1'b1;
      end
      // Spent on each set-first pop, returned by the sink
      credit_q <= credit_q - mask_pkg::credit_t'(pop_o && is_sf)
                           + mask_pkg::credit_t'(out_credit_i);
    end
  end

  assign op_o       = op_q;
  assign vm_o       = vm_q;
  assign clr_o      = start_ok;
  assign count_en_o = pop_o && is_cnt;
  assign sf_en_o    = pop_o && is_sf;
  // Busy covers the done cycle, so the last result slice lands while busy
  assign busy_o     = (state_q != mask_pkg::IDLE);
  assign done_o     = (state_q == mask_pkg::FINISH);

endmodule

`default_nettype wire

// File: hdl/mask_count_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mask unit count datapath
// Popcount and trailing-zero accumulation per slice
// for vcpop and vfirst
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mask_count_unit (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             clr_i,
  input  wire logic             en_i,
  input  wire logic             vm_i,
  input  wire mask_pkg::slice_t slice_i,
  input  wire mask_pkg::slice_t mask_i,
  output mask_pkg::cnt_t        cpop_o,
  output mask_pkg::cnt_t        vfirst_o,
  output logic                  vfirst_found_o
);

  mask_pkg::slice_t active;
  mask_pkg::cnt_t   slice_pop;
  mask_pkg::cnt_t   slice_tz;

  mask_pkg::cnt_t cpop_q, vfirst_q;
  logic           found_q;

  // Unmasked instructions see the operand alone
  assign active = slice_i & (mask_i | {mask_pkg::SliceW{vm_i}});

  always_comb begin
    slice_pop = '0;
    for (int i = 0; i < mask_pkg::SliceW; i++) begin
      slice_pop = slice_pop + mask_pkg::cnt_t'(active[i]);
    end
  end

  // Scan from the top so the lowest set bit wins, full width when empty
  always_comb begin
    slice_tz = mask_pkg::cnt_t'(mask_pkg::SliceW);
    for (int i = mask_pkg::SliceW - 1; i >= 0; i--) begin
      if (active[i]) slice_tz = mask_pkg::cnt_t'(i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cpop_q   <= '0;
      vfirst_q <= '0;
      found_q  <= 1'b0;
    end else if (clr_i) begin
      cpop_q   <= '0;
      vfirst_q <= '0;
      found_q  <= 1'b0;
    end else if (en_i) begin
      cpop_q <= cpop_q + slice_pop;
      // Index stops growing once the first one has been seen
      if (!found_q) vfirst_q <= vfirst_q + slice_tz;
      found_q <= found_q | (|active);
    end
  end

  assign cpop_o         = cpop_q;
  assign vfirst_o       = vfirst_q;
  assign vfirst_found_o = found_q;

endmodule

`default_nettype wire

// File: hdl/mask_set_first_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mask unit set-first datapath
// vmsbf / vmsif / vmsof per slice with a found-one
// carry and a registered result slice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mask_set_first_unit (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             clr_i,
  input  wire logic             en_i,
  input  wire mask_pkg::op_t    op_i,
  input  wire logic             vm_i,
  input  wire mask_pkg::slice_t slice_i,
  input  wire mask_pkg::slice_t mask_i,
  output logic                  out_valid_o,
  output mask_pkg::slice_t      out_slice_o
);

  mask_pkg::slice_t active, sbf, sif, sof, res;
  logic             found_q, valid_q;
  mask_pkg::slice_t slice_q;

  assign active = slice_i & (mask_i | {mask_pkg::SliceW{vm_i}});

  // Bit i stays set while no active one has appeared up to i
  always_comb begin
    sbf[0] = ~(active[0] | found_q);
    for (int i = 1; i < mask_pkg::SliceW; i++) begin
      sbf[i] = sbf[i-1] & ~active[i];
    end
  end

  assign sif = {sbf[mask_pkg::SliceW-2:0], ~found_q};
  assign sof = ~sbf & sif;

  always_comb begin
    unique case (op_i)
      mask_pkg::OP_VMSBF: res = sbf;
      mask_pkg::OP_VMSIF: res = sif;
      mask_pkg::OP_VMSOF: res = sof;
      default:            res = '1;
    endcase
    // Masked-off positions read back as one
    res = res | ~(mask_i | {mask_pkg::SliceW{vm_i}});
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= en_i;
      if (clr_i)     found_q <= 1'b0;
      else if (en_i) found_q <= found_q | (|active);
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) slice_q <= res;
  end

  assign out_valid_o = valid_q;
  assign out_slice_o = slice_q;

endmodule

`default_nettype wire

// File: hdl/mask_unit_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mask unit top level
// Credit-based slice input, sequencer, count and
// set-first datapaths for the vector mask ALU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mask_unit_top (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             start_i,
  input  wire mask_pkg::op_t    op_i,
  input  wire logic             vm_i,
  input  wire logic             in_valid_i,
  input  wire mask_pkg::slice_t in_slice_i,
  input  wire mask_pkg::slice_t in_mask_i,
  input  wire logic             out_credit_i,
  output logic                  in_credit_o,
  output logic                  out_valid_o,
  output mask_pkg::slice_t      out_slice_o,
  output logic                  busy_o,
  output logic                  done_o,
  output mask_pkg::cnt_t        cpop_o,
  output mask_pkg::cnt_t        vfirst_o,
  output logic                  vfirst_found_o
);

  mask_pkg::slice_t head_slice, head_mask;
  mask_pkg::op_t    op;
  logic             fifo_empty, pop, vm, clr, count_en, sf_en;

  mask_in_fifo i_in_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (in_valid_i),
    .slice_i      (in_slice_i),
    .mask_i       (in_mask_i),
    .pop_i        (pop),
    .head_slice_o (head_slice),
    .head_mask_o  (head_mask),
    .empty_o      (fifo_empty),
    .credit_o     (in_credit_o)
  );

  mask_seq_ctrl i_seq_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .op_i         (op_i),
    .vm_i         (vm_i),
    .fifo_empty_i (fifo_empty),
    .out_credit_i (out_credit_i),
    .pop_o        (pop),
    .op_o         (op),
    .vm_o         (vm),
    .clr_o        (clr),
    .count_en_o   (count_en),
    .sf_en_o      (sf_en),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  // Both datapaths read the buffer head in the pop cycle
  mask_count_unit i_count_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clr_i          (clr),
    .en_i           (count_en),
    .vm_i           (vm),
    .slice_i        (head_slice),
    .mask_i         (head_mask),
    .cpop_o         (cpop_o),
    .vfirst_o       (vfirst_o),
    .vfirst_found_o (vfirst_found_o)
  );

  mask_set_first_unit i_set_first_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clr_i       (clr),
    .en_i        (sf_en),
    .op_i        (op),
    .vm_i        (vm),
    .slice_i     (head_slice),
    .mask_i      (head_mask),
    .out_valid_o (out_valid_o),
    .out_slice_o (out_slice_o)
  );

endmodule

`default_nettype wire

// File: tb/mask_unit_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mask unit protocol assertions
// Output credits, done pulse and credit return timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mask_unit_sva (
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic busy_i,
  input wire logic done_i,
  input wire logic out_valid_i,
  input wire logic out_credit_i,
  input wire logic in_credit_i,
  input wire logic pop_i
);

  // Slices the sink holds without having returned a credit
  int out_owed;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_owed <= 0;
    end else begin
      out_owed <= out_owed + int'(out_valid_i) - int'(out_credit_i);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_owed >= 0) && (out_owed <= int'(mask_pkg::OutCredits)))
    else $error("output credits overdrawn");

  assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i)
    else $error("done longer than one cycle");

  assert property (@(posedge clk_i) disable iff (!rst_ni) !busy_i |-> !out_valid_i)
    else $error("output valid while idle");

  assert property (@(posedge clk_i) disable iff (!rst_ni) in_credit_i |-> $past(pop_i))
    else $error("input credit without a pop");

endmodule

bind mask_unit_top mask_unit_sva i_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .busy_i       (busy_o),
  .done_i       (done_o),
  .out_valid_i  (out_valid_o),
  .out_credit_i (out_credit_i),
  .in_credit_i  (in_credit_o),
  .pop_i        (pop)
);

`default_nettype wire

// File: tb/mask_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mask unit testbench
// Directed tests for vcpop, vfirst and the set-first
// instructions with credit-driven source and sink
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mask_unit_tb;

  localparam int ClkPeriod = 8;
  // Roughly 30 instructions, none longer than about 80 cycles
  localparam int MaxCycles = 2500;
  localparam mask_pkg::op_t SfOps [3] = '{mask_pkg::OP_VMSBF, mask_pkg::OP_VMSIF,
                                          mask_pkg::OP_VMSOF};

  typedef logic [mask_pkg::VlenBits-1:0] vec_t;

  logic             clk_i, rst_ni, start_i, vm_i, in_valid_i, out_credit_i;
  mask_pkg::op_t    op_i;
  mask_pkg::slice_t in_slice_i, in_mask_i, out_slice_o;
  logic             in_credit_o, out_valid_o, busy_o, done_o, vfirst_found_o;
  mask_pkg::cnt_t   cpop_o, vfirst_o;

  vec_t        opnd_v, mask_v;
  logic [15:0] lfsr_q = 16'd91;

  mask_unit_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(MaxCycles * ClkPeriod);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int i = 0; i < mask_pkg::VlenBits; i++) begin
      v[i] = lfsr_bit();
    end
    return v;
  endfunction

  // Whole-vector result from the index of the first active one
  function automatic vec_t ref_set_first(input mask_pkg::op_t op, input logic vm,
                                         input int first);
    vec_t r;
    for (int i = 0; i < mask_pkg::VlenBits; i++) begin
      case (op)
        mask_pkg::OP_VMSBF: r[i] = (i < first);
        mask_pkg::OP_VMSIF: r[i] = (i <= first);
        default:            r[i] = (i == first);
      endcase
      if (!vm && !mask_v[i]) r[i] = 1'b1;
    end
    return r;
  endfunction

  task automatic fail_with(input string what);
    $display("%s at %0t", what, $time);
    $display("TEST FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  // One instruction; the sink holds credits until cycle hold, then returns one every gap cycles
  task automatic run_op(input mask_pkg::op_t op, input logic vm, input int hold,
                        input int gap, input int restart);
    vec_t act, exp_sf;
    int   exp_pop, first, cyc, sent, credits, returns, outs, owed;
    logic is_sf, done, go;
    act = vm ? opnd_v : (opnd_v & mask_v);
    exp_pop = 0;
    first = mask_pkg::VlenBits;
    for (int i = mask_pkg::VlenBits - 1; i >= 0; i--) begin
      if (act[i]) begin
        exp_pop++;
        first = i;
      end
    end
    exp_sf = ref_set_first(op, vm, first);
    is_sf = (op == mask_pkg::OP_VMSBF) || (op == mask_pkg::OP_VMSIF) ||
            (op == mask_pkg::OP_VMSOF);
    cyc = 0;
    sent = 0;
    credits = mask_pkg::InDepth;
    returns = 0;
    outs = 0;
    owed = 0;
    done = 1'b0;
    @(posedge clk_i);
    #1;
    start_i = 1'b1;
    op_i = op;
    vm_i = vm;
    while (!done) begin
      @(posedge clk_i);
      #1;
      // A second start while busy, with a different instruction
      start_i = (cyc == restart);
      op_i = (op == mask_pkg::OP_VCPOP) ? mask_pkg::OP_VMSOF : mask_pkg::OP_VCPOP;
      vm_i = !vm;
      if (!done_o) begin
        compare("busy_o while running", 32'(busy_o), 1);
      end
      // Pop, credit return and result slice share the same one-cycle delay
      if (is_sf) begin
        compare("out_valid_o with in_credit_o", 32'(out_valid_o), 32'(in_credit_o));
      end
      if (in_credit_o) begin
        credits++;
        returns++;
      end
      if (out_valid_o) begin
        if (!is_sf || outs >= mask_pkg::NrSlices) fail_with("Unexpected output slice");
        compare($sformatf("out_slice_o[%0d]", outs), 32'(out_slice_o),
                32'(exp_sf[outs*mask_pkg::SliceW +: mask_pkg::SliceW]));
        outs++;
        owed++;
      end
      if (hold > 0 && cyc == hold - 1) begin
        compare("out_valid_o count while credits withheld", outs, mask_pkg::OutCredits);
      end
      out_credit_i = (owed > 0) && (cyc >= hold) && (cyc % gap == 0);
      if (out_credit_i) owed--;
      go = lfsr_bit();
      in_valid_i = 1'b0;
      if (sent < mask_pkg::NrSlices && credits > 0 && go) begin
        in_valid_i = 1'b1;
        in_slice_i = opnd_v[sent*mask_pkg::SliceW +: mask_pkg::SliceW];
        in_mask_i = mask_v[sent*mask_pkg::SliceW +: mask_pkg::SliceW];
        sent++;
        credits--;
      end
      done = done_o;
      cyc++;
    end
    // Done follows the last pop by one cycle, as does its credit
    compare("in_credit_o at done_o", 32'(in_credit_o), 1);
    compare("in_credit_o returns", returns, mask_pkg::NrSlices);
    compare("out_valid_o count", outs, is_sf ? mask_pkg::NrSlices : 0);
    if (!is_sf) begin
      compare("cpop_o", 32'(cpop_o), exp_pop);
      compare("vfirst_o", 32'(vfirst_o), first);
      compare("vfirst_found_o", 32'(vfirst_found_o), 32'(first < mask_pkg::VlenBits));
    end
    // Hand back what the sink still holds so the next instruction starts full
    while (owed > 0) begin
      @(posedge clk_i);
      #1;
      out_credit_i = 1'b1;
      owed--;
    end
    @(posedge clk_i);
    #1;
    out_credit_i = 1'b0;
    compare("busy_o after done", 32'(busy_o), 0);
  endtask

  task automatic test_cpop_unmasked();
    opnd_v = rand_vec();
    mask_v = rand_vec();
    run_op(mask_pkg::OP_VCPOP, 1'b1, 0, 1, -1);
  endtask

  task automatic test_count_masked();
    opnd_v = rand_vec();
    mask_v = rand_vec();
    run_op(mask_pkg::OP_VCPOP, 1'b0, 0, 1, -1);
    run_op(mask_pkg::OP_VFIRST, 1'b0, 0, 1, -1);
    // Operand one at bit 7 is masked off, so bit 93 is first
    opnd_v = '0;
    opnd_v[7] = 1'b1;
    opnd_v[93] = 1'b1;
    mask_v[7] = 1'b0;
    mask_v[93] = 1'b1;
    run_op(mask_pkg::OP_VFIRST, 1'b0, 0, 1, -1);
    opnd_v = rand_vec();
    mask_v = '0;
    run_op(mask_pkg::OP_VFIRST, 1'b0, 0, 1, -1);
    run_op(mask_pkg::OP_VCPOP, 1'b0, 0, 1, -1);
  endtask

  task automatic test_set_first_unmasked();
    for (int k = 0; k < 3; k++) begin
      for (int p = 0; p < 4; p++) begin
        mask_v = rand_vec();
        case (p)
          0:       opnd_v = rand_vec();
          1:       opnd_v = rand_vec() << 50;
          2:       opnd_v = vec_t'(1) << (mask_pkg::VlenBits - 1);
          default: opnd_v = '0;
        endcase
        run_op(SfOps[k], 1'b1, 0, 1, -1);
      end
    end
  endtask

  task automatic test_set_first_masked();
    for (int k = 0; k < 3; k++) begin
      opnd_v = rand_vec();
      mask_v = rand_vec();
      run_op(SfOps[k], 1'b0, 0, 1, -1);
      opnd_v = '0;
      opnd_v[3] = 1'b1;
      opnd_v[40] = 1'b1;
      opnd_v[77] = 1'b1;
      mask_v = rand_vec();
      mask_v[3] = 1'b0;
      mask_v[40] = 1'b1;
      run_op(SfOps[k], 1'b0, 0, 1, -1);
    end
  endtask

  task automatic test_out_backpressure();
    opnd_v = rand_vec() << 20;
    mask_v = rand_vec();
    run_op(mask_pkg::OP_VMSIF, 1'b1, 40, 3, -1);
  endtask

  task automatic test_in_credits();
    opnd_v = rand_vec() << 70;
    mask_v = rand_vec();
    run_op(mask_pkg::OP_VMSOF, 1'b0, 0, 1, 5);
  endtask

  initial begin
    rst_ni = 1'b0;
    start_i = 1'b0;
    op_i = mask_pkg::OP_VCPOP;
    vm_i = 1'b0;
    in_valid_i = 1'b0;
    in_slice_i = '0;
    in_mask_i = '0;
    out_credit_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    compare("{busy_o,done_o,out_valid_o,in_credit_o} in reset",
            32'({busy_o, done_o, out_valid_o, in_credit_o}), 0);
    rst_ni = 1'b1;
    test_cpop_unmasked();
    test_count_masked();
    test_set_first_unmasked();
    test_set_first_masked();
    test_out_backpressure();
    test_in_credits();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/mask_pkg.sv
hdl/mask_in_fifo.sv
hdl/mask_seq_ctrl.sv
hdl/mask_count_unit.sv
hdl/mask_set_first_unit.sv
hdl/mask_unit_top.sv
tb/mask_unit_sva.sv
tb/mask_unit_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the mask unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mask_unit_tb -f files.f -o mask_unit_sim

./obj_dir/mask_unit_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  exit 0
else
  exit 1
fi
